/* source/dcache_consts.svh */
// --------------------------------------
// geometry of the two-way data cache
// one 64-bit word per line, 64 sets
// tag, index and offset widths must add
// up to the address width
// --------------------------------------
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DCACHE_ADDR_W   64
`define DCACHE_DATA_W   64
`define DCACHE_STRB_W   8
`define DCACHE_SETS     64
`define DCACHE_INDEX_W  6
`define DCACHE_OFFSET_W 3
`define DCACHE_TAG_W    55
`define DCACHE_AGE_W    3
`define DCACHE_AGE_MAX  7

`endif

/* source/dcache_addr_pkg.sv */
// --------------------------------------
// address fields and data types
// offset bits are never stored
// --------------------------------------
`default_nettype none

`include "dcache_consts.svh"

package dcache_addr_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`DCACHE_DATA_W-1:0]  word_t;
    typedef logic [`DCACHE_STRB_W-1:0]  strb_t;
    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic                       way_t;
    typedef logic [`DCACHE_AGE_W-1:0]   age_t;

endpackage

`default_nettype wire

/* source/dcache_ctrl_pkg.sv */
// --------------------------------------
// controller states and the kinds of
// request seen on the memory side
// --------------------------------------
`default_nettype none

package dcache_ctrl_pkg;

    // single request port, reads and writes share one path
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_RESP,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_t;

    typedef enum logic {MEM_REFILL, MEM_WRITEBACK} mem_kind_t;

endpackage

`default_nettype wire

/* source/dcache_way_if.sv */
// --------------------------------------
// controller to tag and data store link
// store outputs are valid one cycle
// after the index is presented
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface dcache_way_if;

    dcache_addr_pkg::index_t index;
    dcache_addr_pkg::tag_t   tag;
    dcache_addr_pkg::word_t  wdata;
    dcache_addr_pkg::strb_t  strb;
    logic                    fill_en;
    dcache_addr_pkg::word_t  fill_data;
    logic                    hit_wr_en;
    logic                    touch_en;

    logic                    hit;
    dcache_addr_pkg::way_t   hit_way;
    dcache_addr_pkg::way_t   victim_way;
    logic                    victim_dirty;
    dcache_addr_pkg::tag_t   victim_tag;

    dcache_addr_pkg::word_t  rdata;
    dcache_addr_pkg::word_t  victim_data;

    modport ctrl (
        output index, tag, wdata, strb, fill_en, fill_data, hit_wr_en, touch_en,
        input  hit, victim_dirty, victim_tag, rdata, victim_data
    );

    modport tags (
        input  index, tag, fill_en, hit_wr_en,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  index, wdata, strb, fill_en, fill_data, hit_wr_en, hit_way, victim_way,
        output rdata, victim_data
    );

endinterface

`default_nettype wire

/* source/dcache_ctrl_fsm.sv */
// --------------------------------------
// request capture and miss handling
// one request in flight at a time
// a miss always returns to LOOKUP, so
// the response comes from a hit
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl_fsm (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       req_valid_i,
    input  logic                       req_we_i,
    input  dcache_addr_pkg::addr_t     req_addr_i,
    input  dcache_addr_pkg::word_t     req_wdata_i,
    input  dcache_addr_pkg::strb_t     req_strb_i,
    input  logic                       mem_ready_i,
    input  dcache_addr_pkg::word_t     mem_rdata_i,
    output logic                       req_ready_o,
    output logic                       resp_valid_o,
    output dcache_addr_pkg::word_t     resp_rdata_o,
    output logic                       mem_req_valid_o,
    output dcache_ctrl_pkg::mem_kind_t mem_req_kind_o,
    output dcache_addr_pkg::addr_t     mem_req_addr_o,
    output dcache_addr_pkg::word_t     mem_req_wdata_o,
    dcache_way_if.ctrl                 way_if
);

    dcache_ctrl_pkg::ctrl_state_t state_q;
    dcache_ctrl_pkg::ctrl_state_t state_d;

    logic                   we_q;
    dcache_addr_pkg::addr_t addr_q;
    dcache_addr_pkg::word_t wdata_q;
    dcache_addr_pkg::strb_t strb_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dcache_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload, only loaded on acceptance
    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            we_q    <= req_we_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_ctrl_pkg::ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = dcache_ctrl_pkg::ST_LOOKUP;
                end
            end
            dcache_ctrl_pkg::ST_LOOKUP: state_d = dcache_ctrl_pkg::ST_COMPARE;
            dcache_ctrl_pkg::ST_COMPARE: begin
                if (way_if.hit) begin
                    state_d = dcache_ctrl_pkg::ST_RESP;
                end else if (way_if.victim_dirty) begin
                    state_d = dcache_ctrl_pkg::ST_WRITEBACK;
                end else begin
                    state_d = dcache_ctrl_pkg::ST_REFILL;
                end
            end
            dcache_ctrl_pkg::ST_RESP: state_d = dcache_ctrl_pkg::ST_IDLE;
            dcache_ctrl_pkg::ST_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = dcache_ctrl_pkg::ST_REFILL;
                end
            end
            dcache_ctrl_pkg::ST_REFILL: begin
                if (mem_ready_i) begin
                    state_d = dcache_ctrl_pkg::ST_LOOKUP;
                end
            end
            default: state_d = dcache_ctrl_pkg::ST_IDLE;
        endcase
    end

    assign way_if.index     = addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign way_if.tag       = addr_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign way_if.wdata     = wdata_q;
    assign way_if.strb      = strb_q;
    assign way_if.touch_en  = (state_q == dcache_ctrl_pkg::ST_COMPARE) && way_if.hit;
    assign way_if.hit_wr_en = way_if.touch_en && we_q;
    assign way_if.fill_en   = (state_q == dcache_ctrl_pkg::ST_REFILL) && mem_ready_i;
    assign way_if.fill_data = mem_rdata_i;

    assign req_ready_o  = (state_q == dcache_ctrl_pkg::ST_IDLE);
    assign resp_valid_o = (state_q == dcache_ctrl_pkg::ST_RESP);
    assign resp_rdata_o = (resp_valid_o && !we_q) ? way_if.rdata : '0;

    assign mem_req_valid_o = (state_q == dcache_ctrl_pkg::ST_WRITEBACK) ||
                             (state_q == dcache_ctrl_pkg::ST_REFILL);

    // victim address is rebuilt from its own tag, not the request
    always_comb begin
        if (state_q == dcache_ctrl_pkg::ST_WRITEBACK) begin
            mem_req_kind_o  = dcache_ctrl_pkg::MEM_WRITEBACK;
            mem_req_addr_o  = {way_if.victim_tag, way_if.index, {`DCACHE_OFFSET_W{1'b0}}};
            mem_req_wdata_o = way_if.victim_data;
        end else begin
            mem_req_kind_o  = dcache_ctrl_pkg::MEM_REFILL;
            mem_req_addr_o  = {addr_q[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                               {`DCACHE_OFFSET_W{1'b0}}};
            mem_req_wdata_o = '0;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_age_counters.sv */
// --------------------------------------
// per-set age of each way, saturating
// ties go to way 0
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_age_counters (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  dcache_addr_pkg::index_t index_i,
    input  logic                    touch_en_i,
    input  dcache_addr_pkg::way_t   touch_way_i,
    output dcache_addr_pkg::way_t   lru_way_o
);

    dcache_addr_pkg::age_t age_q [2][`DCACHE_SETS];
    dcache_addr_pkg::way_t other_way;
    dcache_addr_pkg::age_t other_age;

    assign other_way = ~touch_way_i;
    assign other_age = age_q[other_way][index_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            age_q <= '{default: '0};
        end else if (touch_en_i) begin
            age_q[touch_way_i][index_i] <= '0;
            if (other_age != dcache_addr_pkg::age_t'(`DCACHE_AGE_MAX)) begin
                age_q[other_way][index_i] <= other_age + 1'b1;
            end
        end
    end

    assign lru_way_o = (age_q[1][index_i] > age_q[0][index_i]) ? 1'b1 : 1'b0;

endmodule

`default_nettype wire

/* source/dcache_tag_store.sv */
// --------------------------------------
// tag, valid and dirty bits of two ways
// read registered every cycle, so the
// compare is valid one cycle after index
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_store (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  dcache_addr_pkg::way_t lru_way_i,
    dcache_way_if.tags            way_if,
    output dcache_addr_pkg::way_t touch_way_o
);

    dcache_addr_pkg::tag_t tag_mem [2][`DCACHE_SETS];
    dcache_addr_pkg::tag_t tag_rd  [2];

    logic [1:0][`DCACHE_SETS-1:0] valid_q;
    logic [1:0][`DCACHE_SETS-1:0] dirty_q;
    logic [1:0]                   valid_rd;
    logic [1:0]                   dirty_rd;
    logic [1:0]                   way_hit;

    always_ff @(posedge clk) begin
        if (way_if.fill_en) begin
            tag_mem[way_if.victim_way][way_if.index] <= way_if.tag;
        end
        for (int w = 0; w < 2; w++) begin
            tag_rd[w] <= tag_mem[w][way_if.index];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            valid_rd <= '0;
            dirty_rd <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                valid_rd[w] <= valid_q[w][way_if.index];
                dirty_rd[w] <= dirty_q[w][way_if.index];
            end
            // a fresh line is clean
            if (way_if.fill_en) begin
                valid_q[way_if.victim_way][way_if.index] <= 1'b1;
                dirty_q[way_if.victim_way][way_if.index] <= 1'b0;
            end
            if (way_if.hit_wr_en) begin
                dirty_q[way_if.hit_way][way_if.index] <= 1'b1;
            end
        end
    end

    assign way_hit[0] = valid_rd[0] && (tag_rd[0] == way_if.tag);
    assign way_hit[1] = valid_rd[1] && (tag_rd[1] == way_if.tag);

    assign way_if.hit     = |way_hit;
    assign way_if.hit_way = way_hit[1];
    assign touch_way_o    = way_if.hit_way;

    // empty way first, then least recently used
    assign way_if.victim_way   = !valid_rd[0] ? 1'b0 :
                                 !valid_rd[1] ? 1'b1 : lru_way_i;
    assign way_if.victim_dirty = valid_rd[way_if.victim_way] && dirty_rd[way_if.victim_way];
    assign way_if.victim_tag   = tag_rd[way_if.victim_way];

endmodule

`default_nettype wire

/* source/dcache_data_store.sv */
// --------------------------------------
// data words of both ways, no reset
// write hit and fill never coincide
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_store (
    input logic        clk,
    dcache_way_if.data way_if
);

    dcache_addr_pkg::word_t data_mem [2][`DCACHE_SETS];
    dcache_addr_pkg::word_t data_rd  [2];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            data_rd[w] <= data_mem[w][way_if.index];
        end
        // only strobed bytes change on a write hit
        if (way_if.hit_wr_en) begin
            for (int b = 0; b < `DCACHE_STRB_W; b++) begin
                if (way_if.strb[b]) begin
                    data_mem[way_if.hit_way][way_if.index][8*b +: 8] <= way_if.wdata[8*b +: 8];
                end
            end
        end
        if (way_if.fill_en) begin
            data_mem[way_if.victim_way][way_if.index] <= way_if.fill_data;
        end
    end

    assign way_if.rdata       = data_rd[way_if.hit_way];
    assign way_if.victim_data = data_rd[way_if.victim_way];

endmodule

`default_nettype wire

/* source/dcache_top.sv */
// --------------------------------------
// two-way write-back data cache
// hit latency is three cycles from
// acceptance, a miss takes longer
// mem side waits on mem_ready_i
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      req_valid_i,
    input  logic                      req_we_i,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr_i,
    input  logic [`DCACHE_DATA_W-1:0] req_wdata_i,
    input  logic [`DCACHE_STRB_W-1:0] req_strb_i,
    output logic                      req_ready_o,
    output logic                      resp_valid_o,
    output logic [`DCACHE_DATA_W-1:0] resp_rdata_o,
    output logic                      mem_req_valid_o,
    output logic                      mem_req_kind_o,
    output logic [`DCACHE_ADDR_W-1:0] mem_req_addr_o,
    output logic [`DCACHE_DATA_W-1:0] mem_req_wdata_o,
    input  logic                      mem_ready_i,
    input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i
);

    logic lru_way;
    logic touch_way;

    dcache_way_if way_if ();

    dcache_ctrl_fsm ctrl_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_we_i        (req_we_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_strb_i      (req_strb_i),
        .mem_ready_i     (mem_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .req_ready_o     (req_ready_o),
        .resp_valid_o    (resp_valid_o),
        .resp_rdata_o    (resp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_kind_o  (mem_req_kind_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .way_if          (way_if.ctrl)
    );

    dcache_age_counters age_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .index_i     (way_if.index),
        .touch_en_i  (way_if.touch_en),
        .touch_way_i (touch_way),
        .lru_way_o   (lru_way)
    );

    dcache_tag_store tags_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lru_way_i   (lru_way),
        .way_if      (way_if.tags),
        .touch_way_o (touch_way)
    );

    dcache_data_store data_i (
        .clk    (clk),
        .way_if (way_if.data)
    );

endmodule

`default_nettype wire

/* bench/dcache_clk_gen.sv */
// --------------------------------------
// testbench clock, 100 ns period
// reset held low for three rising edges
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/dcache_props.sv */
// --------------------------------------
// protocol checks bound into dcache_top
// fail_cnt holds the number of failures
// hit latency is checked from acceptance
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_props (
    input logic                      clk,
    input logic                      arst_n_i,
    input logic                      req_valid_i,
    input logic                      req_ready_i,
    input logic                      resp_valid_i,
    input logic                      mem_valid_i,
    input logic                      mem_kind_i,
    input logic [`DCACHE_ADDR_W-1:0] mem_addr_i,
    input logic [`DCACHE_DATA_W-1:0] mem_wdata_i,
    input logic                      mem_ready_i
);

    int   fail_cnt = 0;
    logic accept;

    assign accept = req_valid_i && req_ready_i;

    reset_idle: assert property (@(posedge clk)
        !arst_n_i |-> req_ready_i && !resp_valid_i && !mem_valid_i)
        else begin
            fail_cnt++;
            $error("outputs not idle during reset");
        end

    // LOOKUP and COMPARE never answer
    no_early_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(accept) || $past(accept, 2) |-> !resp_valid_i && !mem_valid_i)
        else begin
            fail_cnt++;
            $error("response or memory request before COMPARE ended");
        end

    // third cycle after acceptance: hit response or a miss request
    hit_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(accept, 3) |-> resp_valid_i != mem_valid_i)
        else begin
            fail_cnt++;
            $error("no hit response three cycles after acceptance");
        end

    resp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        resp_valid_i |=> !resp_valid_i && req_ready_i)
        else begin
            fail_cnt++;
            $error("response longer than one cycle or cache not ready after it");
        end

    mem_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_kind_i) &&
            $stable(mem_addr_i) && $stable(mem_wdata_i))
        else begin
            fail_cnt++;
            $error("memory request changed while waiting for ready");
        end

    // a stalled memory transfer keeps the CPU side blocked
    mem_blocks_cpu: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_valid_i && !mem_ready_i |=> !req_ready_i && !resp_valid_i)
        else begin
            fail_cnt++;
            $error("cache ready for a request while memory was not ready");
        end

endmodule

bind dcache_top dcache_props props_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .resp_valid_i(resp_valid_o),
    .mem_valid_i (mem_req_valid_o),
    .mem_kind_i  (mem_req_kind_o),
    .mem_addr_i  (mem_req_addr_o),
    .mem_wdata_i (mem_req_wdata_o),
    .mem_ready_i (mem_ready_i)
);

`default_nettype wire

/* bench/dcache_tb.sv */
// --------------------------------------
// testbench for dcache_top
// memory answers after a random delay
// each request is waited for with a
// cycle limit, the run never hangs
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT = 200;
    localparam dcache_addr_pkg::word_t FILL_XOR = 64'hA5A5_0000_5A5A_0000;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    logic                   req_we;
    dcache_addr_pkg::addr_t req_addr;
    dcache_addr_pkg::word_t req_wdata;
    dcache_addr_pkg::strb_t req_strb;
    logic                   req_ready;
    logic                   resp_valid;
    dcache_addr_pkg::word_t resp_rdata;
    logic                   mem_valid;
    logic                   mem_kind;
    dcache_addr_pkg::addr_t mem_addr;
    dcache_addr_pkg::word_t mem_wdata;
    logic                   mem_ready = 1'b0;
    dcache_addr_pkg::word_t mem_rdata = '0;

    // memory contents and every completed transfer
    dcache_addr_pkg::word_t     mem_store [dcache_addr_pkg::addr_t];
    dcache_ctrl_pkg::mem_kind_t log_kind [$];
    dcache_addr_pkg::addr_t     log_addr [$];
    dcache_addr_pkg::word_t     log_data [$];

    logic [31:0] lfsr = 32'h57411dc6;
    logic        mem_busy = 1'b0;
    int          mem_wait = 0;
    int          stall = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    string       test_name;

    dcache_clk_gen clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    dcache_top dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .req_valid_i     (req_valid),
        .req_we_i        (req_we),
        .req_addr_i      (req_addr),
        .req_wdata_i     (req_wdata),
        .req_strb_i      (req_strb),
        .req_ready_o     (req_ready),
        .resp_valid_o    (resp_valid),
        .resp_rdata_o    (resp_rdata),
        .mem_req_valid_o (mem_valid),
        .mem_req_kind_o  (mem_kind),
        .mem_req_addr_o  (mem_addr),
        .mem_req_wdata_o (mem_wdata),
        .mem_ready_i     (mem_ready),
        .mem_rdata_i     (mem_rdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic dcache_addr_pkg::word_t mem_word(input dcache_addr_pkg::addr_t a);
        if (mem_store.exists(a)) begin
            return mem_store[a];
        end
        return a ^ FILL_XOR;
    endfunction

    function automatic dcache_addr_pkg::word_t merge_bytes(input dcache_addr_pkg::word_t old,
                                                           input dcache_addr_pkg::word_t wd,
                                                           input dcache_addr_pkg::strb_t st);
        dcache_addr_pkg::word_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (st[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic dcache_addr_pkg::addr_t line_addr(input logic [54:0] tag,
                                                         input logic [5:0] index);
        return {tag, index, 3'b000};
    endfunction

    // memory model, ready after 0..3 cycles plus the test's stall
    always @(posedge clk or negedge arst_n) begin
        logic [1:0] delay;
        if (!arst_n) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
            log_kind.push_back(dcache_ctrl_pkg::mem_kind_t'(mem_kind));
            log_addr.push_back(mem_addr);
            log_data.push_back(mem_wdata);
            if (dcache_ctrl_pkg::mem_kind_t'(mem_kind) == dcache_ctrl_pkg::MEM_WRITEBACK) begin
                mem_store[mem_addr] = mem_wdata;
            end
        end else if (mem_valid) begin
            if (!mem_busy) begin
                lfsr = lfsr_step(lfsr);
                delay[0] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                mem_wait <= int'(delay) + stall;
                mem_busy <= 1'b1;
            end else if (mem_wait == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem_word(mem_addr);
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    task automatic finish_run();
        int total;
        total = errors + dut_i.props_i.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic wait_timeout(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        errors++;
        finish_run();
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_mem(input int idx, input dcache_ctrl_pkg::mem_kind_t kind,
                             input dcache_addr_pkg::addr_t addr,
                             input dcache_addr_pkg::word_t data);
        if (idx >= log_addr.size()) begin
            $display("memory request %0d missing in test %s", idx, test_name);
            errors++;
        end else begin
            check("mem kind", 64'(kind), 64'(log_kind[idx]));
            check("mem addr", addr, log_addr[idx]);
            check("mem wdata", data, log_data[idx]);
        end
    endtask

    task automatic test_begin(input string name);
        test_name = name;
        errors_at_start = errors + dut_i.props_i.fail_cnt;
    endtask

    task automatic test_end();
        int now_errors;
        // let the bound checks of the last request finish
        repeat (2) @(posedge clk);
        now_errors = errors + dut_i.props_i.fail_cnt;
        tests_run++;
        if (now_errors == errors_at_start) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", test_name, now_errors - errors_at_start);
        end
    endtask

    task automatic cpu_access(input logic we, input dcache_addr_pkg::addr_t addr,
                              input dcache_addr_pkg::word_t wdata,
                              input dcache_addr_pkg::strb_t strb,
                              output dcache_addr_pkg::word_t rdata);
        int n;
        @(posedge clk);
        req_valid <= 1'b1;
        req_we    <= we;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_strb  <= strb;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) wait_timeout("req_ready");
        end while (!req_ready);
        @(posedge clk);
        req_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) wait_timeout("resp_valid");
        end while (!resp_valid);
        rdata = resp_rdata;
    endtask

    initial begin
        dcache_addr_pkg::addr_t a;
        dcache_addr_pkg::word_t rd;
        dcache_addr_pkg::word_t xm;
        int log_n;
        int n;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_strb  = '0;
        test_name = "reset";
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) wait_timeout("reset release");
        end while (!arst_n);

        test_begin("reset");
        check("req_ready", 64'd1, 64'(req_ready));
        check("resp_valid", 64'd0, 64'(resp_valid));
        check("mem_valid", 64'd0, 64'(mem_valid));
        test_end();

        // offset bits set on purpose, refill must be aligned
        test_begin("read_miss");
        a = line_addr(55'h11, 6'd5);
        log_n = log_addr.size();
        cpu_access(1'b0, a | 64'h5, '0, '0, rd);
        check("mem requests", 64'd1, 64'(log_addr.size() - log_n));
        check_mem(log_n, dcache_ctrl_pkg::MEM_REFILL, a, '0);
        check("rdata", a ^ FILL_XOR, rd);
        test_end();

        test_begin("read_hit");
        log_n = log_addr.size();
        cpu_access(1'b0, a, '0, '0, rd);
        check("rdata", a ^ FILL_XOR, rd);
        check("mem requests", 64'd0, 64'(log_addr.size() - log_n));
        test_end();

        test_begin("write_hit");
        log_n = log_addr.size();
        xm = merge_bytes(a ^ FILL_XOR, 64'h1122_3344_5566_7788, 8'b0000_1111);
        cpu_access(1'b1, a, 64'h1122_3344_5566_7788, 8'b0000_1111, rd);
        check("write rdata", '0, rd);
        cpu_access(1'b0, a, '0, '0, rd);
        check("rdata", xm, rd);
        check("mem requests", 64'd0, 64'(log_addr.size() - log_n));
        test_end();

        // X dirty in way 0, Y in way 1 touched last, Z evicts X
        test_begin("eviction");
        a = line_addr(55'h21, 6'd9);
        xm = merge_bytes(a ^ FILL_XOR, 64'hDEAD_BEEF_0BAD_F00D, 8'b1100_0011);
        cpu_access(1'b0, a, '0, '0, rd);
        cpu_access(1'b1, a, 64'hDEAD_BEEF_0BAD_F00D, 8'b1100_0011, rd);
        cpu_access(1'b0, line_addr(55'h22, 6'd9), '0, '0, rd);
        log_n = log_addr.size();
        cpu_access(1'b0, line_addr(55'h23, 6'd9), '0, '0, rd);
        check("rdata", line_addr(55'h23, 6'd9) ^ FILL_XOR, rd);
        check_mem(log_n, dcache_ctrl_pkg::MEM_WRITEBACK, a, xm);
        check_mem(log_n + 1, dcache_ctrl_pkg::MEM_REFILL, line_addr(55'h23, 6'd9), '0);
        cpu_access(1'b0, a, '0, '0, rd);
        check("written back rdata", xm, rd);
        test_end();

        // slow memory on a refill and on a dirty write-back
        test_begin("backpressure");
        stall = 5;
        a = line_addr(55'h31, 6'd12);
        cpu_access(1'b1, a, 64'h0123_4567_89AB_CDEF, 8'hFF, rd);
        cpu_access(1'b0, line_addr(55'h32, 6'd12), '0, '0, rd);
        cpu_access(1'b0, line_addr(55'h33, 6'd12), '0, '0, rd);
        check("rdata", line_addr(55'h33, 6'd12) ^ FILL_XOR, rd);
        cpu_access(1'b0, a, '0, '0, rd);
        check("written back rdata", 64'h0123_4567_89AB_CDEF, rd);
        stall = 0;
        test_end();

        finish_run();
    end

endmodule

`default_nettype wire

/* dcache.f */
+incdir+source
source/dcache_addr_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_way_if.sv
source/dcache_ctrl_fsm.sv
source/dcache_age_counters.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_top.sv
bench/dcache_clk_gen.sv
bench/dcache_props.sv
bench/dcache_tb.sv

/* Makefile */
BIN  := obj_dir/Vdcache_tb
SRCS := $(wildcard source/*.sv source/*.svh bench/*.sv)

$(BIN): dcache.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f dcache.f \
		--top-module dcache_tb -o Vdcache_tb

run: $(BIN)
	-./$(BIN) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
